/* Bender.yml */
package:
  name: rename_front

sources:
  - logic/rename_pkg.sv
  - logic/inst_queue.sv
  - logic/free_list.sv
  - logic/reg_alias_table.sv
  - logic/preg_status.sv
  - logic/rob_tracker.sv
  - logic/dispatcher.sv
  - logic/rename_top.sv
  - target: test
    files:
      - sim/tb_rename.sv

/* logic/dispatcher.sv */
// Dispatcher: pop decision, register decode, intra-pair bypass and dispatch outputs
module dispatcher
    import rename_pkg::*;
(
    input  logic    clk,
    input  logic    rst,
    input  logic    iq_empty,
    input  logic    rs_full,
    input  logic    rob_full,
    input  logic    fl_low,
    input  logic    head_lane_valid [dispatch_width],
    input  inst_t   head_inst [dispatch_width],
    input  pc_t     head_pc [dispatch_width],
    input  preg_t   new_preg [dispatch_width],
    input  rob_id_t rob_id [dispatch_width],
    input  preg_t   map_preg1 [dispatch_width],
    input  preg_t   map_preg2 [dispatch_width],
    input  logic    src_ready [2*dispatch_width],
    output logic    iq_pop,
    output areg_t   map_areg1 [dispatch_width],
    output areg_t   map_areg2 [dispatch_width],
    output logic    rat_wr_en [dispatch_width],
    output areg_t   rat_wr_areg [dispatch_width],
    output preg_t   rat_wr_preg [dispatch_width],
    output logic    status_clear_en [dispatch_width],
    output preg_t   status_preg [2*dispatch_width],
    output logic    dispatch_valid,
    output logic    dispatch_lane_valid [dispatch_width],
    output inst_t   dispatch_inst [dispatch_width],
    output pc_t     dispatch_pc [dispatch_width],
    output rob_id_t dispatch_rob_id [dispatch_width],
    output areg_t   dispatch_rd_areg [dispatch_width],
    output preg_t   dispatch_rd_preg [dispatch_width],
    output preg_t   dispatch_rs1_preg [dispatch_width],
    output preg_t   dispatch_rs2_preg [dispatch_width],
    output logic    dispatch_rs1_ready [dispatch_width],
    output logic    dispatch_rs2_ready [dispatch_width]
);

    logic [6:0] opcode [dispatch_width];
    logic       use_rs1 [dispatch_width];
    logic       use_rs2 [dispatch_width];
    logic       use_rd [dispatch_width];
    logic       byp_rs1;
    logic       byp_rs2;

    // Pop only when every downstream resource can take a whole pair
    assign iq_pop = !iq_empty && !rs_full && !rob_full && !fl_low;

    always_ff @(posedge clk) begin
        if (rst) dispatch_valid <= 1'b0;
        else dispatch_valid <= iq_pop;
    end

    // Bundle, new pregs and ROB ids captured on the pop edge
    always_ff @(posedge clk) begin
        if (iq_pop) begin
            dispatch_lane_valid <= head_lane_valid;
            dispatch_inst       <= head_inst;
            dispatch_pc         <= head_pc;
            dispatch_rd_preg    <= new_preg;
            dispatch_rob_id     <= rob_id;
        end
    end

    // Field decode on the registered bundle
    always_comb begin
        for (int i = 0; i < dispatch_width; i++) begin
            opcode[i]  = dispatch_inst[i][6:0];
            // U-type and JAL read nothing
            use_rs1[i] = !(opcode[i] == op_lui || opcode[i] == op_auipc
                           || opcode[i] == op_jal);
            // I-type forms read rs1 only
            use_rs2[i] = use_rs1[i] && !(opcode[i] == op_imm
                           || opcode[i] == op_load || opcode[i] == op_jalr);
            // Stores and branches carry immediate bits in the rd field
            use_rd[i]  = !(opcode[i] == op_store || opcode[i] == op_branch);

            // Unused sources read x0, which gives p0 and ready
            map_areg1[i]        = use_rs1[i] ? dispatch_inst[i][19:15] : '0;
            map_areg2[i]        = use_rs2[i] ? dispatch_inst[i][24:20] : '0;
            dispatch_rd_areg[i] = use_rd[i] ? dispatch_inst[i][11:7] : '0;

            // x0 and empty lanes leave the map alone
            rat_wr_en[i]       = dispatch_valid && dispatch_lane_valid[i]
                                 && dispatch_rd_areg[i] != '0;
            rat_wr_areg[i]     = dispatch_rd_areg[i];
            rat_wr_preg[i]     = dispatch_rd_preg[i];
            status_clear_en[i] = rat_wr_en[i];

            // Status lookups, rs1 then rs2 per lane
            status_preg[2*i]   = map_preg1[i];
            status_preg[2*i+1] = map_preg2[i];
        end
    end

    // Lane 1 source written by lane 0 takes lane 0's new preg
    assign byp_rs1 = dispatch_lane_valid[0] && dispatch_rd_areg[0] != '0
                     && map_areg1[1] == dispatch_rd_areg[0];
    assign byp_rs2 = dispatch_lane_valid[0] && dispatch_rd_areg[0] != '0
                     && map_areg2[1] == dispatch_rd_areg[0];

    // Lane 0 has nothing older in the pair
    assign dispatch_rs1_preg[0]  = map_preg1[0];
    assign dispatch_rs2_preg[0]  = map_preg2[0];
    assign dispatch_rs1_ready[0] = src_ready[0];
    assign dispatch_rs2_ready[0] = src_ready[1];

    assign dispatch_rs1_preg[1]  = byp_rs1 ? dispatch_rd_preg[0] : map_preg1[1];
    assign dispatch_rs2_preg[1]  = byp_rs2 ? dispatch_rd_preg[0] : map_preg2[1];
    assign dispatch_rs1_ready[1] = byp_rs1 ? 1'b0 : src_ready[2];
    assign dispatch_rs2_ready[1] = byp_rs2 ? 1'b0 : src_ready[3];

endmodule

/* logic/free_list.sv */
// Free list: circular queue of free physical registers, paired pop, single push
module free_list
    import rename_pkg::*;
(
    input  logic  clk,
    input  logic  rst,
    input  logic  pop,
    input  logic  push,
    input  preg_t push_preg,
    output preg_t pop_preg [dispatch_width],
    output logic  low
);

    preg_t   mem [fl_depth];
    fl_ptr_t head;
    fl_ptr_t tail;
    fl_cnt_t count;

    // Queue state, reset to p32..p63 in order
    always_ff @(posedge clk) begin
        if (rst) begin
            for (int i = 0; i < fl_depth; i++) begin
                mem[i] <= preg_t'(arch_regs + i);
            end
            head  <= '0;
            // Full at reset, so tail wraps back onto head
            tail  <= '0;
            count <= fl_cnt_t'(fl_depth);
        end else begin
            if (push) begin
                mem[tail] <= push_preg;
                tail      <= tail + fl_ptr_t'(1);
            end
            // Two entries leave per pop
            if (pop) head <= head + fl_ptr_t'(2);
            case ({pop, push})
                2'b10:   count <= count - fl_cnt_t'(2);
                2'b11:   count <= count - fl_cnt_t'(1);
                2'b01:   count <= count + fl_cnt_t'(1);
                default: count <= count;
            endcase
        end
    end

    // Two oldest free registers, lane 0 gets the head
    assign pop_preg[0] = mem[head];
    assign pop_preg[1] = mem[head + fl_ptr_t'(1)];

    // Not enough for a full bundle
    assign low = (count < fl_cnt_t'(2));

    // Pairs only leave when a pair is there
    assert property (@(posedge clk) disable iff (rst) !(pop && low));

    // Retire never returns more registers than the queue can hold
    assert property (@(posedge clk) disable iff (rst)
        (push && !pop) |-> (count < fl_cnt_t'(fl_depth)));

endmodule

/* logic/inst_queue.sv */
// Instruction queue: circular FIFO of two-lane fetch bundles
module inst_queue
    import rename_pkg::*;
(
    input  logic    clk,
    input  logic    rst,
    input  logic    push,
    input  logic    push_lane_valid [dispatch_width],
    input  inst_t   push_inst [dispatch_width],
    input  pc_t     push_pc [dispatch_width],
    input  logic    pop,
    output logic    head_lane_valid [dispatch_width],
    output inst_t   head_inst [dispatch_width],
    output pc_t     head_pc [dispatch_width],
    output logic    empty,
    output logic    full
);

    // Bundle storage, one slot per queued bundle
    logic    mem_valid [iq_depth][dispatch_width];
    inst_t   mem_inst [iq_depth][dispatch_width];
    pc_t     mem_pc [iq_depth][dispatch_width];

    iq_ptr_t head;
    iq_ptr_t tail;
    iq_cnt_t count;

    // Pointers and count
    always_ff @(posedge clk) begin
        if (rst) begin
            head  <= '0;
            tail  <= '0;
            count <= '0;
        end else begin
            if (push) tail <= tail + iq_ptr_t'(1);
            if (pop) head <= head + iq_ptr_t'(1);
            // Simultaneous push and pop leaves the count alone
            if (push && !pop) count <= count + iq_cnt_t'(1);
            else if (pop && !push) count <= count - iq_cnt_t'(1);
        end
    end

    // Payload write, no reset
    always_ff @(posedge clk) begin
        if (push) begin
            for (int i = 0; i < dispatch_width; i++) begin
                mem_valid[tail][i] <= push_lane_valid[i];
                mem_inst[tail][i]  <= push_inst[i];
                mem_pc[tail][i]    <= push_pc[i];
            end
        end
    end

    // Head slot straight out of the storage flops
    assign head_lane_valid = mem_valid[head];
    assign head_inst       = mem_inst[head];
    assign head_pc         = mem_pc[head];

    assign empty = (count == '0);
    assign full  = (count == iq_cnt_t'(iq_depth));

    // Fetch must respect full, dispatch must respect empty
    assert property (@(posedge clk) disable iff (rst) !(push && full));
    assert property (@(posedge clk) disable iff (rst) !(pop && empty));

endmodule

/* logic/preg_status.sv */
// Physical register status: one ready bit per preg with writeback pass-through
module preg_status
    import rename_pkg::*;
(
    input  logic  clk,
    input  logic  rst,
    input  logic  clear_en [dispatch_width],
    input  preg_t clear_preg [dispatch_width],
    input  logic  wb_valid,
    input  preg_t wb_preg,
    input  preg_t rd_preg [2*dispatch_width],
    output logic  rd_ready [2*dispatch_width]
);

    logic [preg_count-1:0] ready;

    always_ff @(posedge clk) begin
        if (rst) begin
            ready <= '1;
        end else begin
            if (wb_valid) ready[wb_preg] <= 1'b1;
            // Allocation applied last so it wins over a set
            for (int i = 0; i < dispatch_width; i++) begin
                if (clear_en[i]) ready[clear_preg[i]] <= 1'b0;
            end
        end
    end

    // p0 is always ready; same-cycle writeback passes through
    always_comb begin
        for (int i = 0; i < 2*dispatch_width; i++) begin
            rd_ready[i] = (rd_preg[i] == '0) || ready[rd_preg[i]]
                       || (wb_valid && wb_preg == rd_preg[i]);
        end
    end

endmodule

/* logic/reg_alias_table.sv */
// Register alias table: architectural to physical map, two reads per lane, two writes
module reg_alias_table
    import rename_pkg::*;
(
    input  logic  clk,
    input  logic  rst,
    input  areg_t rd_areg1 [dispatch_width],
    input  areg_t rd_areg2 [dispatch_width],
    output preg_t rd_preg1 [dispatch_width],
    output preg_t rd_preg2 [dispatch_width],
    input  logic  wr_en [dispatch_width],
    input  areg_t wr_areg [dispatch_width],
    input  preg_t wr_preg [dispatch_width]
);

    preg_t map [arch_regs];

    // Identity map at reset, xN -> pN
    always_ff @(posedge clk) begin
        if (rst) begin
            for (int r = 0; r < arch_regs; r++) begin
                map[r] <= preg_t'(r);
            end
        end else begin
            // Later lane overrides earlier one on the same register
            for (int i = 0; i < dispatch_width; i++) begin
                // x0 stays pinned to p0
                if (wr_en[i] && wr_areg[i] != '0) begin
                    map[wr_areg[i]] <= wr_preg[i];
                end
            end
        end
    end

    // Combinational read, sees the map from before this cycle's writes
    always_comb begin
        for (int i = 0; i < dispatch_width; i++) begin
            rd_preg1[i] = map[rd_areg1[i]];
            rd_preg2[i] = map[rd_areg2[i]];
        end
    end

endmodule

/* logic/rename_pkg.sv */
// Rename package: widths, depths, opcodes and typedefs for the rename front end
package rename_pkg;

    // Lanes per fetch and dispatch bundle
    localparam int dispatch_width = 2;

    // Register file sizes
    localparam int arch_regs  = 32;
    localparam int preg_count = 64;

    // Queue depths
    localparam int rob_depth = 8;
    localparam int iq_depth  = 4;
    // Free list only ever holds the pregs beyond the architectural set
    localparam int fl_depth  = preg_count - arch_regs;

    // RV32I major opcodes that change source or destination usage
    localparam logic [6:0] op_lui    = 7'b0110111;
    localparam logic [6:0] op_auipc  = 7'b0010111;
    localparam logic [6:0] op_jal    = 7'b1101111;
    localparam logic [6:0] op_jalr   = 7'b1100111;
    localparam logic [6:0] op_load   = 7'b0000011;
    localparam logic [6:0] op_imm    = 7'b0010011;
    localparam logic [6:0] op_store  = 7'b0100011;
    localparam logic [6:0] op_branch = 7'b1100011;

    // Register indices
    typedef logic [$clog2(arch_regs)-1:0]  areg_t;
    typedef logic [$clog2(preg_count)-1:0] preg_t;
    typedef logic [$clog2(rob_depth)-1:0]  rob_id_t;

    // Instruction word and program counter
    typedef logic [31:0] inst_t;
    typedef logic [31:0] pc_t;

    // Pointers and occupancy counts
    typedef logic [$clog2(iq_depth)-1:0]    iq_ptr_t;
    typedef logic [$clog2(iq_depth+1)-1:0]  iq_cnt_t;
    typedef logic [$clog2(fl_depth)-1:0]    fl_ptr_t;
    typedef logic [$clog2(fl_depth+1)-1:0]  fl_cnt_t;
    typedef logic [$clog2(rob_depth+1)-1:0] rob_cnt_t;

endpackage

/* logic/rename_top.sv */
// Rename top: instruction queue, free list, RAT, status table, ROB tracker and dispatcher
module rename_top
    import rename_pkg::*;
(
    input  logic    clk,
    input  logic    rst,
    input  logic    fetch_push,
    input  logic    fetch_lane_valid [dispatch_width],
    input  inst_t   fetch_inst [dispatch_width],
    input  pc_t     fetch_pc [dispatch_width],
    input  logic    rs_full,
    input  logic    wb_valid,
    input  preg_t   wb_preg,
    input  logic    retire_valid,
    input  preg_t   retire_preg,
    output logic    iq_full,
    output logic    rob_full,
    output logic    dispatch_valid,
    output logic    dispatch_lane_valid [dispatch_width],
    output inst_t   dispatch_inst [dispatch_width],
    output pc_t     dispatch_pc [dispatch_width],
    output rob_id_t dispatch_rob_id [dispatch_width],
    output areg_t   dispatch_rd_areg [dispatch_width],
    output preg_t   dispatch_rd_preg [dispatch_width],
    output preg_t   dispatch_rs1_preg [dispatch_width],
    output preg_t   dispatch_rs2_preg [dispatch_width],
    output logic    dispatch_rs1_ready [dispatch_width],
    output logic    dispatch_rs2_ready [dispatch_width]
);

    // Queue head and pop handshake
    logic    iq_empty;
    logic    iq_pop;
    logic    head_lane_valid [dispatch_width];
    inst_t   head_inst [dispatch_width];
    pc_t     head_pc [dispatch_width];

    // Allocation
    logic    fl_low;
    preg_t   new_preg [dispatch_width];
    rob_id_t rob_id [dispatch_width];

    // RAT and status lookups
    areg_t   map_areg1 [dispatch_width];
    areg_t   map_areg2 [dispatch_width];
    preg_t   map_preg1 [dispatch_width];
    preg_t   map_preg2 [dispatch_width];
    logic    rat_wr_en [dispatch_width];
    areg_t   rat_wr_areg [dispatch_width];
    preg_t   rat_wr_preg [dispatch_width];
    logic    status_clear_en [dispatch_width];
    preg_t   status_preg [2*dispatch_width];
    logic    src_ready [2*dispatch_width];

    inst_queue u_iq (
        .clk, .rst,
        .push(fetch_push), .push_lane_valid(fetch_lane_valid),
        .push_inst(fetch_inst), .push_pc(fetch_pc), .pop(iq_pop),
        .head_lane_valid, .head_inst, .head_pc,
        .empty(iq_empty), .full(iq_full)
    );

    // Retire hands one preg back per strobe
    free_list u_fl (
        .clk, .rst,
        .pop(iq_pop), .push(retire_valid), .push_preg(retire_preg),
        .pop_preg(new_preg), .low(fl_low)
    );

    reg_alias_table u_rat (
        .clk, .rst,
        .rd_areg1(map_areg1), .rd_areg2(map_areg2),
        .rd_preg1(map_preg1), .rd_preg2(map_preg2),
        .wr_en(rat_wr_en), .wr_areg(rat_wr_areg), .wr_preg(rat_wr_preg)
    );

    // New destinations go not ready together with the RAT update
    preg_status u_status (
        .clk, .rst,
        .clear_en(status_clear_en), .clear_preg(rat_wr_preg),
        .wb_valid, .wb_preg,
        .rd_preg(status_preg), .rd_ready(src_ready)
    );

    rob_tracker u_rob (
        .clk, .rst,
        .alloc(iq_pop), .retire(retire_valid),
        .next_id(rob_id), .full(rob_full)
    );

    dispatcher u_disp (
        .clk, .rst,
        .iq_empty, .rs_full, .rob_full, .fl_low,
        .head_lane_valid, .head_inst, .head_pc,
        .new_preg, .rob_id, .map_preg1, .map_preg2, .src_ready,
        .iq_pop, .map_areg1, .map_areg2,
        .rat_wr_en, .rat_wr_areg, .rat_wr_preg,
        .status_clear_en, .status_preg,
        .dispatch_valid, .dispatch_lane_valid, .dispatch_inst, .dispatch_pc,
        .dispatch_rob_id, .dispatch_rd_areg, .dispatch_rd_preg,
        .dispatch_rs1_preg, .dispatch_rs2_preg,
        .dispatch_rs1_ready, .dispatch_rs2_ready
    );

endmodule

/* logic/rob_tracker.sv */
// ROB tracker: tail id counter and occupancy count with full flag
module rob_tracker
    import rename_pkg::*;
(
    input  logic    clk,
    input  logic    rst,
    input  logic    alloc,
    input  logic    retire,
    output rob_id_t next_id [dispatch_width],
    output logic    full
);

    rob_id_t  tail;
    rob_cnt_t occupancy;

    always_ff @(posedge clk) begin
        if (rst) begin
            tail      <= '0;
            occupancy <= '0;
        end else begin
            // Id wraps modulo rob_depth by width
            if (alloc) tail <= tail + rob_id_t'(2);
            case ({alloc, retire})
                2'b10:   occupancy <= occupancy + rob_cnt_t'(2);
                2'b11:   occupancy <= occupancy + rob_cnt_t'(1);
                2'b01:   occupancy <= occupancy - rob_cnt_t'(1);
                default: occupancy <= occupancy;
            endcase
        end
    end

    assign next_id[0] = tail;
    assign next_id[1] = tail + rob_id_t'(1);

    // No room for another pair
    assign full = (occupancy > rob_cnt_t'(rob_depth - 2));

    // Occupancy bound also checks that retire never outruns allocation
    assert property (@(posedge clk) disable iff (rst)
        occupancy <= rob_cnt_t'(rob_depth));
    assert property (@(posedge clk) disable iff (rst)
        retire |-> (occupancy != '0 || alloc));

endmodule

/* sim/tb_rename.sv */
// Testbench for rename_top: clock, stimulus, reference rename model, compare process and report
module tb_rename
    import rename_pkg::*;
();
    timeunit 1ns;
    timeprecision 1ps;

    // One fetch bundle as pushed, lane 0 in the low slot
    typedef struct packed {
        logic [1:0]      lv;
        inst_t [1:0]     inst;
        pc_t [1:0]       pc;
    } bundle_t;

    logic    clk;
    logic    rst;
    logic    fetch_push;
    logic    fetch_lane_valid [dispatch_width];
    inst_t   fetch_inst [dispatch_width];
    pc_t     fetch_pc [dispatch_width];
    logic    rs_full;
    logic    wb_valid;
    preg_t   wb_preg;
    logic    retire_valid;
    preg_t   retire_preg;
    logic    iq_full;
    logic    rob_full;
    logic    dispatch_valid;
    logic    dispatch_lane_valid [dispatch_width];
    inst_t   dispatch_inst [dispatch_width];
    pc_t     dispatch_pc [dispatch_width];
    rob_id_t dispatch_rob_id [dispatch_width];
    areg_t   dispatch_rd_areg [dispatch_width];
    preg_t   dispatch_rd_preg [dispatch_width];
    preg_t   dispatch_rs1_preg [dispatch_width];
    preg_t   dispatch_rs2_preg [dispatch_width];
    logic    dispatch_rs1_ready [dispatch_width];
    logic    dispatch_rs2_ready [dispatch_width];

    // Reference model state
    preg_t   m_rat [arch_regs];
    logic    m_ready [preg_count];
    preg_t   m_free [$];
    rob_id_t m_rob;
    bundle_t exp_q [$];
    preg_t   in_flight [$];
    // Expected fields of the bundle being dispatched
    preg_t   e_rs1 [2];
    preg_t   e_rs2 [2];
    preg_t   e_rd [2];
    logic    e_r1 [2];
    logic    e_r2 [2];
    areg_t   e_rda [2];
    rob_id_t e_rob [2];
    preg_t   last_rd [2];
    rob_id_t last_rob [2];

    logic [31:0] rng_state;
    pc_t     pc_next;
    int      checks;
    int      errors;
    int      errors_before;
    bit      auto_retire;
    bit      auto_wb;
    bit      auto_rs;

    rename_top i_dut (
        .clk, .rst, .fetch_push, .fetch_lane_valid, .fetch_inst, .fetch_pc,
        .rs_full, .wb_valid, .wb_preg, .retire_valid, .retire_preg,
        .iq_full, .rob_full, .dispatch_valid, .dispatch_lane_valid,
        .dispatch_inst, .dispatch_pc, .dispatch_rob_id, .dispatch_rd_areg,
        .dispatch_rd_preg, .dispatch_rs1_preg, .dispatch_rs2_preg,
        .dispatch_rs1_ready, .dispatch_rs2_ready
    );

    initial begin
        clk = 1'b0;
        forever #20 clk = ~clk;
    end

    function automatic logic [31:0] xorshift();
        rng_state = rng_state ^ (rng_state << 13);
        rng_state = rng_state ^ (rng_state >> 17);
        rng_state = rng_state ^ (rng_state << 5);
        return rng_state;
    endfunction

    function automatic inst_t r_type(areg_t rd, areg_t rs1, areg_t rs2);
        return {7'b0, rs2, rs1, 3'b0, rd, 7'b0110011};
    endfunction

    function automatic inst_t i_type(areg_t rd, areg_t rs1);
        return {12'd5, rs1, 3'b0, rd, op_imm};
    endfunction

    function automatic inst_t lui_type(areg_t rd);
        return {20'h12345, rd, op_lui};
    endfunction

    function automatic bundle_t make_bundle(inst_t a, inst_t b, logic [1:0] lv);
        bundle_t r;
        r.lv      = lv;
        r.inst[0] = a;
        r.inst[1] = b;
        r.pc[0]   = pc_next;
        r.pc[1]   = pc_next + 4;
        pc_next   = pc_next + 8;
        return r;
    endfunction

    // R, I, LUI and store forms with random fields
    function automatic inst_t random_inst();
        logic [31:0] r;
        r = xorshift();
        case (r[1:0])
            2'd0:    return r_type(r[6:2], r[11:7], r[16:12]);
            2'd1:    return i_type(r[6:2], r[11:7]);
            2'd2:    return lui_type(r[6:2]);
            default: return {7'b0, r[16:12], r[11:7], 3'b010, r[6:2], op_store};
        endcase
    endfunction

    function automatic bundle_t random_bundle();
        logic [31:0] r;
        inst_t a;
        inst_t b;
        a = random_inst();
        b = random_inst();
        r = xorshift();
        // Empty lanes are rare
        return make_bundle(a, b, {r[3:0] != 0, r[7:4] != 0});
    endfunction

    function automatic logic src_is_ready(preg_t p);
        return p == '0 || m_ready[p] || (wb_valid && wb_preg == p);
    endfunction

    // Reference rename of one bundle against the model state
    function automatic void predict(bundle_t b);
        logic [6:0] op;
        logic u1;
        logic u2;
        areg_t s1;
        areg_t s2;
        for (int i = 0; i < 2; i++) begin
            op = b.inst[i][6:0];
            u1 = !(op == op_lui || op == op_auipc || op == op_jal);
            u2 = u1 && !(op == op_imm || op == op_load || op == op_jalr);
            s1 = u1 ? b.inst[i][19:15] : '0;
            s2 = u2 ? b.inst[i][24:20] : '0;
            e_rda[i] = (op == op_store || op == op_branch) ? '0 : b.inst[i][11:7];
            e_rd[i]  = m_free[i];
            e_rob[i] = m_rob + rob_id_t'(i);
            e_rs1[i] = m_rat[s1];
            e_rs2[i] = m_rat[s2];
            e_r1[i]  = src_is_ready(e_rs1[i]);
            e_r2[i]  = src_is_ready(e_rs2[i]);
            // Lane 1 depends on lane 0 inside the pair
            if (i == 1 && b.lv[0] && e_rda[0] != '0) begin
                if (s1 == e_rda[0]) begin
                    e_rs1[1] = e_rd[0];
                    e_r1[1]  = 1'b0;
                end
                if (s2 == e_rda[0]) begin
                    e_rs2[1] = e_rd[0];
                    e_r2[1]  = 1'b0;
                end
            end
        end
    endfunction

    task automatic compare_field(string name, int lane, logic [31:0] e, logic [31:0] a);
        checks++;
        if (e !== a) begin
            errors++;
            $display("error at %0t: %s[%0d] expected %h got %h", $time, name, lane, e, a);
        end
    endtask

    // Compare process, sampled mid-cycle where outputs are settled
    initial begin
        bundle_t b;
        bit got;
        forever begin
            @(negedge clk);
            got = 1'b0;
            if (!rst && dispatch_valid) begin
                if (exp_q.size() == 0) begin
                    errors++;
                    $display("dispatch seen at %0t with no bundle pending", $time);
                end else begin
                    got = 1'b1;
                    b = exp_q.pop_front();
                    predict(b);
                    for (int i = 0; i < 2; i++) begin
                        compare_field("dispatch_lane_valid", i, b.lv[i], dispatch_lane_valid[i]);
                        compare_field("dispatch_inst", i, b.inst[i], dispatch_inst[i]);
                        compare_field("dispatch_pc", i, b.pc[i], dispatch_pc[i]);
                        compare_field("dispatch_rob_id", i, e_rob[i], dispatch_rob_id[i]);
                        compare_field("dispatch_rd_areg", i, e_rda[i], dispatch_rd_areg[i]);
                        compare_field("dispatch_rd_preg", i, e_rd[i], dispatch_rd_preg[i]);
                        compare_field("dispatch_rs1_preg", i, e_rs1[i], dispatch_rs1_preg[i]);
                        compare_field("dispatch_rs2_preg", i, e_rs2[i], dispatch_rs2_preg[i]);
                        compare_field("dispatch_rs1_ready", i, e_r1[i], dispatch_rs1_ready[i]);
                        compare_field("dispatch_rs2_ready", i, e_r2[i], dispatch_rs2_ready[i]);
                    end
                end
            end
            if (!rst && wb_valid) m_ready[wb_preg] = 1'b1;
            // Clear after set, as the status table does
            if (got) begin
                for (int i = 0; i < 2; i++) begin
                    if (b.lv[i] && e_rda[i] != '0) begin
                        m_rat[e_rda[i]]  = e_rd[i];
                        m_ready[e_rd[i]] = 1'b0;
                    end
                    in_flight.push_back(m_free.pop_front());
                    // Last values seen on the DUT outputs
                    last_rd[i]  = dispatch_rd_preg[i];
                    last_rob[i] = dispatch_rob_id[i];
                end
                m_rob = m_rob + rob_id_t'(2);
            end
            if (!rst && retire_valid) m_free.push_back(retire_preg);
        end
    end

    // One clock step; strobes drop and the back end acts if enabled
    task automatic tick();
        logic [31:0] r;
        @(posedge clk);
        #2;
        fetch_push   = 1'b0;
        wb_valid     = 1'b0;
        retire_valid = 1'b0;
        r = xorshift();
        if (auto_retire && in_flight.size() > 0 && r[0]) begin
            retire_valid = 1'b1;
            retire_preg  = in_flight.pop_front();
        end
        if (auto_wb && r[2:1] == 2'd0) begin
            wb_valid = 1'b1;
            wb_preg  = preg_t'(32 + r[7:3]);
        end
        if (auto_rs) rs_full = (r[10:8] == 3'd0);
    endtask

    task automatic push_bundle(bundle_t b);
        int n;
        n = 0;
        while (iq_full && n < 200) begin
            tick();
            n++;
        end
        if (iq_full) begin
            errors++;
            $display("timeout: instruction queue stayed full for 200 cycles");
        end else begin
            for (int i = 0; i < 2; i++) begin
                fetch_lane_valid[i] = b.lv[i];
                fetch_inst[i]       = b.inst[i];
                fetch_pc[i]         = b.pc[i];
            end
            exp_q.push_back(b);
            fetch_push = 1'b1;
            tick();
        end
    endtask

    task automatic drain(string what);
        int n;
        n = 0;
        while (exp_q.size() != 0 && n < 200) begin
            tick();
            n++;
        end
        if (exp_q.size() != 0) begin
            errors++;
            $display("timeout: %s bundles were not dispatched within 200 cycles", what);
        end
    endtask

    task automatic report(string name);
        $display("test %s finished, %0d new errors", name, errors - errors_before);
        errors_before = errors;
    endtask

    initial begin
        int n;
        int hold;
        rng_state = 32'd60;
        pc_next = 32'h1000;
        checks = 0;
        errors = 0;
        errors_before = 0;
        auto_retire = 1'b0;
        auto_wb = 1'b0;
        auto_rs = 1'b0;
        rst = 1'b1;
        fetch_push = 1'b0;
        rs_full = 1'b0;
        wb_valid = 1'b0;
        wb_preg = '0;
        retire_valid = 1'b0;
        retire_preg = '0;
        for (int i = 0; i < 2; i++) begin
            fetch_lane_valid[i] = 1'b0;
            fetch_inst[i] = '0;
            fetch_pc[i] = '0;
        end
        // Model starts from the DUT reset state
        for (int r = 0; r < arch_regs; r++) m_rat[r] = preg_t'(r);
        for (int p = 0; p < preg_count; p++) m_ready[p] = 1'b1;
        for (int p = arch_regs; p < preg_count; p++) m_free.push_back(preg_t'(p));
        m_rob = '0;
        repeat (3) @(posedge clk);
        #2;
        rst = 1'b0;

        // 1: first bundle after reset
        checks += 2;
        if (dispatch_valid !== 1'b0 || iq_full !== 1'b0) begin
            errors++;
            $display("dispatch_valid or iq_full not low after reset");
        end
        auto_retire = 1'b1;
        push_bundle(make_bundle(r_type(1, 3, 4), r_type(2, 5, 6), 2'b11));
        drain("reset");
        compare_field("first rd_preg", 0, 32, last_rd[0]);
        compare_field("first rd_preg", 1, 33, last_rd[1]);
        compare_field("first rob_id", 0, 0, last_rob[0]);
        compare_field("first rob_id", 1, 1, last_rob[1]);
        report("reset_state");

        // 2: random stream with a random back end
        auto_wb = 1'b1;
        auto_rs = 1'b1;
        for (int k = 0; k < 40; k++) push_bundle(random_bundle());
        drain("random stream");
        auto_wb = 1'b0;
        auto_rs = 1'b0;
        rs_full = 1'b0;
        report("random_rename");

        // 3: lane 1 reads lane 0 rd, then rd x0
        push_bundle(make_bundle(i_type(7, 1), r_type(8, 7, 0), 2'b11));
        push_bundle(make_bundle(r_type(0, 2, 3), r_type(9, 0, 0), 2'b11));
        drain("dependency");
        report("pair_dependency_x0");

        // 4: not ready until writeback, with same-cycle pass-through
        push_bundle(make_bundle(r_type(10, 8, 8), lui_type(11), 2'b11));
        push_bundle(make_bundle(i_type(12, 11), r_type(13, 0, 0), 2'b11));
        drain("readiness");
        push_bundle(make_bundle(r_type(14, 7, 7), i_type(15, 7), 2'b11));
        n = 0;
        while (!dispatch_valid && n < 200) begin
            tick();
            n++;
        end
        if (!dispatch_valid) begin
            errors++;
            $display("timeout: no dispatch for the writeback bundle");
        end else begin
            wb_valid = 1'b1;
            wb_preg  = m_rat[7];
        end
        drain("writeback");
        report("readiness");

        // 5: reservation station back-pressure until the queue is full
        rs_full = 1'b1;
        for (int k = 0; k < iq_depth; k++) push_bundle(random_bundle());
        checks++;
        if (!iq_full) begin
            errors++;
            $display("iq_full stayed low with %0d bundles queued", iq_depth);
        end
        hold = 3 + int'(xorshift() % 8);
        for (int k = 0; k < hold; k++) begin
            tick();
            checks++;
            if (dispatch_valid) begin
                errors++;
                $display("dispatch while rs_full was held high at %0t", $time);
            end
        end
        rs_full = 1'b0;
        drain("back-pressure");
        report("back_pressure");

        // 6: ROB exhaustion without retire, then recovery
        auto_retire = 1'b0;
        for (int k = 0; k < 4; k++) push_bundle(random_bundle());
        n = 0;
        while (!rob_full && n < 200) begin
            tick();
            n++;
        end
        repeat (3) tick();
        checks += 2;
        if (!rob_full) begin
            errors++;
            $display("rob_full never rose with retire stopped");
        end
        if (dispatch_valid) begin
            errors++;
            $display("dispatch continued after the ROB filled");
        end
        hold = in_flight.size();
        for (int k = 0; k < hold; k++) begin
            retire_valid = 1'b1;
            retire_preg  = in_flight.pop_front();
            tick();
        end
        auto_retire = 1'b1;
        drain("exhaustion");
        report("resource_exhaustion");

        $display("checks %0d, errors %0d", checks, errors);
        if (errors == 0) begin
            $display("** PASS **");
        end else begin
            $display("** FAIL **");
        end
        $finish;
    end

endmodule

/* tb.f */
logic/rename_pkg.sv
logic/inst_queue.sv
logic/free_list.sv
logic/reg_alias_table.sv
logic/preg_status.sv
logic/rob_tracker.sv
logic/dispatcher.sv
logic/rename_top.sv
sim/tb_rename.sv
